//--- verilog/usb_fe_pkg.sv
package usb_fe_pkg;

    ////////////////////////////////////////////////////////////////////
    // detector widths and codes
    ////////////////////////////////////////////////////////////////////

    localparam int COUNTER_WIDTH = 24;           // timer and wait thresholds

    typedef logic [COUNTER_WIDTH-1:0] counter_t;
    typedef logic [1:0]               speed_t;
    typedef logic [1:0]               linestate_t; // {linestate1, linestate0}

    localparam speed_t SPEED_AUTO = 2'd0;        // not yet known
    localparam speed_t SPEED_LS   = 2'd1;
    localparam speed_t SPEED_FS   = 2'd2;
    localparam speed_t SPEED_HS   = 2'd3;

    localparam linestate_t LINE_SE0  = 2'b00;
    localparam linestate_t LINE_FS_J = 2'b01;
    localparam linestate_t LINE_LS_J = 2'b10;

    ////////////////////////////////////////////////////////////////////
    // wishbone register map
    ////////////////////////////////////////////////////////////////////

    localparam int WB_ADDR_WIDTH = 4;            // word address
    localparam int WB_DATA_WIDTH = 32;

    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

    localparam wb_addr_t REG_CTRL   = 4'd0;      // bit 0: restart detector
    localparam wb_addr_t REG_WAIT1  = 4'd1;      // J hold threshold
    localparam wb_addr_t REG_WAIT2  = 4'd2;      // SE0 hold threshold
    localparam wb_addr_t REG_STATUS = 4'd3;      // speed in bits 1:0

    localparam counter_t WAIT1_RESET = 24'd240;
    localparam counter_t WAIT2_RESET = 24'd120;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat_r;
    } wb_rsp_t;

endpackage

//--- verilog/cdc_pulse.sv
module cdc_pulse (
    input  logic reset_i,
    input  logic src_clk,
    input  logic src_pulse,
    input  logic dst_clk,
    output logic dst_pulse
);

    logic       src_toggle;
    logic [2:0] dst_sync;   // [0] meta, [1] stable, [2] previous

    // source side flips on every request
    always_ff @(posedge src_clk) begin
        if (reset_i) begin
            src_toggle <= 1'b0;
        end else if (src_pulse) begin
            src_toggle <= ~src_toggle;
        end
    end

    always_ff @(posedge dst_clk) begin
        if (reset_i) begin
            dst_sync <= 3'b000;
        end else begin
            dst_sync <= {dst_sync[1:0], src_toggle};
        end
    end

    // one dst cycle per toggle edge
    assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

//--- verilog/usb_autodetect.sv
module usb_autodetect (
    input  logic                  fe_clk,
    input  logic                  reset_i,
    input  usb_fe_pkg::linestate_t linestate,
    input  logic                  restart,
    input  usb_fe_pkg::counter_t  wait1,
    input  usb_fe_pkg::counter_t  wait2,
    output usb_fe_pkg::speed_t    speed
);

    import usb_fe_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_ls,
        st_fshs,
        st_wait_low,
        st_hs,
        st_fs,
        st_done,
        st_error
    } state_e;

    state_e   state;
    state_e   next_state;
    state_e   state_r;      // one cycle behind state
    counter_t timer;
    counter_t wait1_q;
    counter_t wait2_q;

    // thresholds are quasi-static, one fe_clk stage is enough
    always_ff @(posedge fe_clk) begin
        wait1_q <= wait1;
        wait2_q <= wait2;
    end

    ////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (linestate == LINE_LS_J)
                    next_state = st_ls;
                else if (linestate == LINE_FS_J)
                    next_state = st_fshs;
            end
            st_ls: begin
                if (linestate != LINE_LS_J)
                    next_state = st_error;
                else if (timer == wait1_q)
                    next_state = st_done;
            end
            st_fshs: begin
                if (linestate != LINE_FS_J)
                    next_state = st_error;
                else if (timer == wait1_q)
                    next_state = st_wait_low;   // J held long enough, look for chirp
            end
            st_wait_low: begin
                if (linestate == LINE_SE0)
                    next_state = st_hs;
                else if (linestate != LINE_FS_J)
                    next_state = st_error;
            end
            st_hs: begin
                if (timer == wait2_q)
                    next_state = st_done;       // SE0 long enough, high speed
                else if (linestate == LINE_FS_J)
                    next_state = st_fs;
                else if (linestate == LINE_LS_J)
                    next_state = st_error;
            end
            st_fs:    next_state = st_done;
            st_done: begin
                if (restart)
                    next_state = st_idle;
            end
            st_error: next_state = st_idle;
            default:  next_state = st_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // timer and speed result
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            timer <= '0;
        end else if (state == st_idle || state == st_wait_low || restart) begin
            timer <= '0;
        end else if (state == st_ls || state == st_fshs || state == st_hs) begin
            timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            state_r <= st_idle;
            speed   <= SPEED_AUTO;
        end else begin
            state_r <= state;
            if (state == st_idle || state == st_error) begin
                speed <= SPEED_AUTO;
            end else if (state == st_done) begin
                // only the first done cycle sees a useful state_r
                case (state_r)
                    st_ls:   speed <= SPEED_LS;
                    st_fs:   speed <= SPEED_FS;
                    st_hs:   speed <= SPEED_HS;
                    default: speed <= speed;
                endcase
            end
        end
    end

endmodule

//--- verilog/usb_fe_regs.sv
module usb_fe_regs (
    input  logic                 cwusb_clk,
    input  logic                 reset_i,
    input  usb_fe_pkg::wb_req_t  wb_req,
    output usb_fe_pkg::wb_rsp_t  wb_rsp,
    input  usb_fe_pkg::speed_t   speed_fe,
    output usb_fe_pkg::counter_t wait1,
    output usb_fe_pkg::counter_t wait2,
    output logic                 restart_req
);

    import usb_fe_pkg::*;

    logic     ack;
    logic     access;       // new request, not yet acknowledged
    logic     wr_access;
    wb_data_t rd_data;
    wb_data_t rd_mux;
    speed_t   speed_meta;
    speed_t   speed_sync;

    assign access    = wb_req.cyc & wb_req.stb & ~ack;
    assign wr_access = access & wb_req.we;

    ////////////////////////////////////////////////////////////////////
    // bus handshake
    ////////////////////////////////////////////////////////////////////

    // ack for one cycle, then low at least one cycle
    always_ff @(posedge cwusb_clk) begin
        if (reset_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge cwusb_clk) begin
        if (access) begin
            rd_data <= rd_mux;     // held through the ack cycle
        end
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = rd_data;

    ////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge cwusb_clk) begin
        if (reset_i) begin
            wait1       <= WAIT1_RESET;
            wait2       <= WAIT2_RESET;
            restart_req <= 1'b0;
        end else begin
            restart_req <= wr_access && wb_req.adr == REG_CTRL && wb_req.dat_w[0];
            if (wr_access) begin
                case (wb_req.adr)
                    REG_WAIT1: wait1 <= wb_req.dat_w[COUNTER_WIDTH-1:0];
                    REG_WAIT2: wait2 <= wb_req.dat_w[COUNTER_WIDTH-1:0];
                    default: ;     // ctrl handled above, others dropped
                endcase
            end
        end
    end

    // speed changes rarely, two flops suffice
    always_ff @(posedge cwusb_clk) begin
        if (reset_i) begin
            speed_meta <= SPEED_AUTO;
            speed_sync <= SPEED_AUTO;
        end else begin
            speed_meta <= speed_fe;
            speed_sync <= speed_meta;
        end
    end

    always_comb begin
        case (wb_req.adr)
            REG_WAIT1:  rd_mux = wb_data_t'(wait1);
            REG_WAIT2:  rd_mux = wb_data_t'(wait2);
            REG_STATUS: rd_mux = wb_data_t'(speed_sync);
            default:    rd_mux = '0;   // ctrl reads zero too
        endcase
    end

endmodule

//--- verilog/usb_fe_top.sv
module usb_fe_top (
    input  logic                  fe_clk,
    input  logic                  cwusb_clk,
    input  logic                  reset_i,
    input  usb_fe_pkg::linestate_t linestate,
    input  usb_fe_pkg::wb_req_t   wb_req,
    output usb_fe_pkg::wb_rsp_t   wb_rsp,
    output usb_fe_pkg::speed_t    speed
);

    import usb_fe_pkg::*;

    counter_t wait1;
    counter_t wait2;
    logic     restart_req;  // cwusb_clk pulse
    logic     restart;      // fe_clk pulse

    usb_fe_regs u_usb_fe_regs (
        .cwusb_clk   (cwusb_clk),
        .reset_i     (reset_i),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .speed_fe    (speed),
        .wait1       (wait1),
        .wait2       (wait2),
        .restart_req (restart_req)
    );

    cdc_pulse u_restart_cdc (
        .reset_i   (reset_i),
        .src_clk   (cwusb_clk),
        .src_pulse (restart_req),
        .dst_clk   (fe_clk),
        .dst_pulse (restart)
    );

    usb_autodetect u_usb_autodetect (
        .fe_clk    (fe_clk),
        .reset_i   (reset_i),
        .linestate (linestate),
        .restart   (restart),
        .wait1     (wait1),
        .wait2     (wait2),
        .speed     (speed)
    );

endmodule

//--- verification/usb_fe_sva.sv
module usb_fe_sva (
    input logic                 fe_clk,
    input logic                 cwusb_clk,
    input logic                 reset_i,
    input usb_fe_pkg::wb_req_t  wb_req,
    input usb_fe_pkg::wb_rsp_t  wb_rsp,
    input usb_fe_pkg::speed_t   speed
);

    import usb_fe_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // wishbone handshake, cwusb_clk
    ////////////////////////////////////////////////////////////////////

    // ack only while the master holds cyc and stb
    ack_needs_request: assert property (@(posedge cwusb_clk) disable iff (reset_i)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (@(posedge cwusb_clk) disable iff (reset_i)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high for two cycles running");

    ////////////////////////////////////////////////////////////////////
    // detected speed, fe_clk
    ////////////////////////////////////////////////////////////////////

    speed_auto_in_reset: assert property (@(posedge fe_clk)
        reset_i |=> speed == SPEED_AUTO)
        else $error("speed not auto during reset");

    // a result is only replaced by going through auto
    speed_via_auto: assert property (@(posedge fe_clk) disable iff (reset_i)
        speed != $past(speed) |-> ($past(speed) == SPEED_AUTO || speed == SPEED_AUTO))
        else $error("speed jumped between two results");

endmodule

bind usb_fe_top usb_fe_sva u_usb_fe_sva (
    .fe_clk    (fe_clk),
    .cwusb_clk (cwusb_clk),
    .reset_i   (reset_i),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .speed     (speed)
);

//--- verification/usb_fe_tb.sv
module usb_fe_tb;

    import usb_fe_pkg::*;

    localparam int FE_PERIOD  = 8;
    localparam int CW_PERIOD  = 10;
    localparam int BUS_MARGIN = 20000;  // reset and all register accesses

    logic       fe_clk = 1'b0;
    logic       cwusb_clk = 1'b0;
    logic       reset_i = 1'b1;
    linestate_t linestate = LINE_SE0;
    wb_req_t    wb_req = '0;
    wb_rsp_t    wb_rsp;
    speed_t     speed;
    wb_data_t   rd;                     // scratch for writes

    int     check_errors = 0;
    int     timeout_errors = 0;
    int     wait1_val, wait2_val;
    int     hold_ls, hold_fs, se0_short, se0_long, ls_short, wander_len;
    longint watchdog_limit = 0;

    initial forever #(FE_PERIOD / 2) fe_clk = ~fe_clk;
    initial forever #(CW_PERIOD / 2) cwusb_clk = ~cwusb_clk;

    usb_fe_top u_usb_fe_top (
        .fe_clk    (fe_clk),
        .cwusb_clk (cwusb_clk),
        .reset_i   (reset_i),
        .linestate (linestate),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .speed     (speed)
    );

    task automatic close_run();
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////
    // bus and line drivers
    ////////////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t dat_r);
        int waited;
        waited = 0;
        @(posedge cwusb_clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        do begin
            @(posedge cwusb_clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 16);
        dat_r = wb_rsp.dat_r;           // valid during ack
        if (wb_rsp.ack) begin
            @(posedge cwusb_clk);       // ack taken on this edge
            #1;
        end else begin
            timeout_errors++;
            $display("no ack from the register slave at address %0d", adr);
        end
        wb_req = '0;
    endtask

    task automatic check_read(input wb_addr_t adr, input wb_data_t exp);
        wb_data_t got;
        bus_cycle(1'b0, adr, '0, got);
        assert (got === exp)
            else begin
                check_errors++;
                $display("** Error dat_r[%0d]: got 0x%h expected 0x%h", adr, got, exp);
            end
    endtask

    // line held for cycles+1 edges, the first one is the alignment
    task automatic drive_line(input linestate_t ls, input int cycles);
        @(posedge fe_clk);
        #1;
        linestate = ls;
        repeat (cycles) @(posedge fe_clk);
    endtask

    ////////////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////////////

    task automatic expect_speed(input speed_t exp);
        assert (speed === exp)
            else begin
                check_errors++;
                $display("** Error speed: got 0x%h expected 0x%h", speed, exp);
            end
    endtask

    task automatic check_speed(input speed_t exp);
        int       n;
        wb_data_t got;
        n = 0;
        @(posedge fe_clk);
        #1;
        while (speed !== exp && n < 64) begin
            @(posedge fe_clk);
            #1;
            n++;
        end
        expect_speed(exp);
        n = 0;
        do begin                        // status lags by the sync flops
            bus_cycle(1'b0, REG_STATUS, '0, got);
            n++;
        end while (got !== wb_data_t'(exp) && n < 8);
        assert (got === wb_data_t'(exp))
            else begin
                check_errors++;
                $display("** Error STATUS: got 0x%h expected 0x%h", got, exp);
            end
    endtask

    // after done the result ignores the line
    task automatic wander_line(input speed_t held, input int cycles);
        repeat (cycles) begin
            drive_line(linestate_t'($urandom_range(0, 2)), 1);
            #1;
            expect_speed(held);
        end
        drive_line(LINE_SE0, 2);
    endtask

    task automatic restart_detector();
        bus_cycle(1'b1, REG_CTRL, 32'd1, rd);
        check_speed(SPEED_AUTO);
    endtask

    initial begin
        void'($urandom(56309));
        wait1_val  = $urandom_range(8, 40);
        wait2_val  = $urandom_range(8, 40);
        hold_ls    = wait1_val + 4 + $urandom_range(0, 8);
        hold_fs    = wait1_val + 4 + $urandom_range(0, 8);
        se0_short  = $urandom_range(2, wait2_val - 4);
        se0_long   = wait2_val + 4 + $urandom_range(0, 8);
        ls_short   = $urandom_range(2, wait1_val - 4);
        wander_len = 16 + $urandom_range(0, 16);
        watchdog_limit = 20 * FE_PERIOD * (2 * hold_ls + 2 * hold_fs + se0_short + se0_long
                         + ls_short + 2 * wander_len + 30) + BUS_MARGIN;
        repeat (16) @(posedge cwusb_clk);
        @(posedge fe_clk);              // release clear of both clock edges
        #1;
        reset_i = 1'b0;
        // reset values
        check_speed(SPEED_AUTO);
        check_read(REG_WAIT1, wb_data_t'(WAIT1_RESET));
        check_read(REG_WAIT2, wb_data_t'(WAIT2_RESET));
        // thresholds and an unused address
        bus_cycle(1'b1, REG_WAIT1, wb_data_t'(wait1_val), rd);
        bus_cycle(1'b1, REG_WAIT2, wb_data_t'(wait2_val), rd);
        bus_cycle(1'b1, 4'hA, 32'hFFFF_FFFF, rd);
        check_read(REG_WAIT1, wb_data_t'(wait1_val));
        check_read(REG_WAIT2, wb_data_t'(wait2_val));
        check_read(4'hA, '0);
        // low speed, then a free line until restart
        drive_line(LINE_LS_J, hold_ls);
        drive_line(LINE_SE0, 2);
        check_speed(SPEED_LS);
        wander_line(SPEED_LS, wander_len);
        restart_detector();
        // full speed: short chirp
        drive_line(LINE_FS_J, hold_fs);
        drive_line(LINE_SE0, se0_short);
        drive_line(LINE_FS_J, 4);
        check_speed(SPEED_FS);
        drive_line(LINE_SE0, 2);
        restart_detector();
        // high speed: chirp past wait2
        drive_line(LINE_FS_J, hold_fs);
        drive_line(LINE_SE0, se0_long);
        drive_line(LINE_FS_J, 4);
        check_speed(SPEED_HS);
        wander_line(SPEED_HS, wander_len);
        restart_detector();
        // broken ls hold, then a full one
        drive_line(LINE_LS_J, ls_short);
        drive_line(LINE_FS_J, 4);
        drive_line(LINE_SE0, 4);
        check_speed(SPEED_AUTO);
        drive_line(LINE_LS_J, hold_ls);
        check_speed(SPEED_LS);
        close_run();
    end

    initial begin
        wait (watchdog_limit != 0);
        #(watchdog_limit);
        timeout_errors++;
        $display("watchdog expired before the test sequence finished");
        close_run();
    end

endmodule

//--- verilog.f
verilog/usb_fe_pkg.sv
verilog/cdc_pulse.sv
verilog/usb_autodetect.sv
verilog/usb_fe_regs.sv
verilog/usb_fe_top.sv
verification/usb_fe_sva.sv
verification/usb_fe_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= usb_fe_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
LINTFLAGS ?= -Wall
PASS_MSG  ?= Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --assert --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
